// ==== Bender.yml ====
package:
  name: chip_sim_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/chip_pkg.sv
      - logic/por_sequencer.sv
      - logic/pad_map.sv
      - logic/pad_ctrl_regs.sv
      - logic/chip_sim_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/tb_chip_sim.sv

// ==== logic/chip_cfg.svh ====
//////////////////////////////
// pad counts and pad indices
// register offsets, power timing
//////////////////////////////

`ifndef CHIP_CFG_SVH
`define CHIP_CFG_SVH

// pad ring size
`define CHIP_MIO_PADS 40
`define CHIP_DIO_PADS 8

// dedicated pad positions
`define CHIP_DIO_SPI_SCK 0
`define CHIP_DIO_SPI_CSB 1
`define CHIP_DIO_SPI_SD0 2
`define CHIP_DIO_SPI_SD1 3
`define CHIP_DIO_USB_DP  4
`define CHIP_DIO_USB_DN  5

// multiplexed pad positions
`define CHIP_MIO_UART_RX    25
`define CHIP_MIO_UART_TX    26
`define CHIP_MIO_USB_SENSE0 35
`define CHIP_MIO_USB_SENSE1 36

// supply must stay high this many cycles before power-ok
`define CHIP_POK_FILTER 2

// pad control register map, byte offsets
`define CHIP_REG_MIO_OUT_LO 8'h00
`define CHIP_REG_MIO_OUT_HI 8'h04
`define CHIP_REG_MIO_OE_LO  8'h08
`define CHIP_REG_MIO_OE_HI  8'h0C
`define CHIP_REG_DIO_OUT    8'h10
`define CHIP_REG_DIO_OE     8'h14
`define CHIP_REG_MIO_IN_LO  8'h18
`define CHIP_REG_MIO_IN_HI  8'h1C
`define CHIP_REG_DIO_IN     8'h20
`define CHIP_REG_STATUS     8'h24

`endif

// ==== logic/chip_pkg.sv ====
//////////////////////////////
// pad vector types
// AXI4-Lite channel structs
//////////////////////////////

`default_nettype none

`include "chip_cfg.svh"

package chip_pkg;

  // pad and pin vectors
  typedef logic [`CHIP_MIO_PADS-1:0] mio_vec_t;
  typedef logic [`CHIP_DIO_PADS-1:0] dio_vec_t;
  typedef logic [31:0]               gpio_vec_t;

  //////////////////////////////
  // AXI4-Lite
  //////////////////////////////

  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t AXIL_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_SLVERR = 2'b10;

  // manager to subordinate
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // subordinate to manager
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== logic/chip_sim_top.sv ====
//////////////////////////////
// chip wrapper, aon domain
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module chip_sim_top (
  input  wire                      clk_aon,
  input  wire                      arst_n_i,
  input  wire chip_pkg::axil_req_t axil_req_i,
  output chip_pkg::axil_rsp_t      axil_rsp_o,
  output logic                     init_done_o,
  input  wire chip_pkg::gpio_vec_t gpio_i,
  input  wire                      uart_rx_i,
  input  wire                      usb_sense_i,
  input  wire                      spi_sck_i,
  input  wire                      spi_csb_i,
  input  wire                      spi_sdi_i,
  input  wire                      usb_dp_i,
  input  wire                      usb_dn_i,
  output chip_pkg::gpio_vec_t      gpio_o,
  output chip_pkg::gpio_vec_t      gpio_en_o,
  output logic                     uart_tx_o,
  output logic                     uart_tx_en_o,
  output logic                     spi_sdo_o,
  output logic                     spi_sdo_en_o,
  output logic                     usb_dp_o,
  output logic                     usb_dp_en_o,
  output logic                     usb_dn_o,
  output logic                     usb_dn_en_o
);

  chip_pkg::mio_vec_t mio_in;
  chip_pkg::mio_vec_t mio_out;
  chip_pkg::mio_vec_t mio_oe;
  chip_pkg::dio_vec_t dio_in;
  chip_pkg::dio_vec_t dio_out;
  chip_pkg::dio_vec_t dio_oe;

  // power sequence
  por_sequencer u_por (
    .clk_aon     (clk_aon),
    .arst_n_i    (arst_n_i),
    .init_done_o (init_done_o)
  );

  // bus facing pad registers
  pad_ctrl_regs u_regs (
    .clk_aon     (clk_aon),
    .arst_n_i    (arst_n_i),
    .init_done_i (init_done_o),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .mio_in_i    (mio_in),
    .dio_in_i    (dio_in),
    .mio_out_o   (mio_out),
    .mio_oe_o    (mio_oe),
    .dio_out_o   (dio_out),
    .dio_oe_o    (dio_oe)
  );

  pad_map u_pads (
    .gpio_i       (gpio_i),
    .uart_rx_i    (uart_rx_i),
    .usb_sense_i  (usb_sense_i),
    .spi_sck_i    (spi_sck_i),
    .spi_csb_i    (spi_csb_i),
    .spi_sdi_i    (spi_sdi_i),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o),
    .usb_dp_o     (usb_dp_o),
    .usb_dp_en_o  (usb_dp_en_o),
    .usb_dn_o     (usb_dn_o),
    .usb_dn_en_o  (usb_dn_en_o),
    .mio_out_i    (mio_out),
    .mio_oe_i     (mio_oe),
    .dio_out_i    (dio_out),
    .dio_oe_i     (dio_oe),
    .mio_in_o     (mio_in),
    .dio_in_o     (dio_in)
  );

endmodule

`default_nettype wire

// ==== logic/pad_ctrl_regs.sv ====
//////////////////////////////
// AXI4-Lite pad control regs
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chip_cfg.svh"

module pad_ctrl_regs (
  input  wire                     clk_aon,
  input  wire                     arst_n_i,
  input  wire                     init_done_i,
  input  wire chip_pkg::axil_req_t axil_req_i,
  output chip_pkg::axil_rsp_t     axil_rsp_o,
  input  wire chip_pkg::mio_vec_t mio_in_i,
  input  wire chip_pkg::dio_vec_t dio_in_i,
  output chip_pkg::mio_vec_t      mio_out_o,
  output chip_pkg::mio_vec_t      mio_oe_o,
  output chip_pkg::dio_vec_t      dio_out_o,
  output chip_pkg::dio_vec_t      dio_oe_o
);

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

  wr_state_e            wr_state_q;
  rd_state_e            rd_state_q;
  logic                 aw_fire;
  logic                 ar_fire;
  logic                 wr_ok;
  logic                 rd_ok;
  chip_pkg::axil_data_t rd_data;
  chip_pkg::axil_resp_t bresp_q;
  chip_pkg::axil_data_t rdata_q;
  chip_pkg::axil_resp_t rresp_q;
  chip_pkg::mio_vec_t   mio_out_q;
  chip_pkg::mio_vec_t   mio_oe_q;
  chip_pkg::dio_vec_t   dio_out_q;
  chip_pkg::dio_vec_t   dio_oe_q;

  // address and data taken together, one at a time
  assign aw_fire = (wr_state_q == WR_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign ar_fire = (rd_state_q == RD_IDLE) && axil_req_i.arvalid;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // only the out/oe registers take writes, and only after init
  always_comb begin
    case (axil_req_i.awaddr)
      `CHIP_REG_MIO_OUT_LO, `CHIP_REG_MIO_OUT_HI,
      `CHIP_REG_MIO_OE_LO,  `CHIP_REG_MIO_OE_HI,
      `CHIP_REG_DIO_OUT,    `CHIP_REG_DIO_OE: wr_ok = init_done_i;
      default:                                wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_ok   = 1'b1;
    rd_data = '0;
    case (axil_req_i.araddr)
      `CHIP_REG_MIO_OUT_LO: rd_data = mio_out_q[31:0];
      `CHIP_REG_MIO_OUT_HI: rd_data = chip_pkg::axil_data_t'(mio_out_q[`CHIP_MIO_PADS-1:32]);
      `CHIP_REG_MIO_OE_LO:  rd_data = mio_oe_q[31:0];
      `CHIP_REG_MIO_OE_HI:  rd_data = chip_pkg::axil_data_t'(mio_oe_q[`CHIP_MIO_PADS-1:32]);
      `CHIP_REG_DIO_OUT:    rd_data = chip_pkg::axil_data_t'(dio_out_q);
      `CHIP_REG_DIO_OE:     rd_data = chip_pkg::axil_data_t'(dio_oe_q);
      `CHIP_REG_MIO_IN_LO:  rd_data = mio_in_i[31:0];
      `CHIP_REG_MIO_IN_HI:  rd_data = chip_pkg::axil_data_t'(mio_in_i[`CHIP_MIO_PADS-1:32]);
      `CHIP_REG_DIO_IN:     rd_data = chip_pkg::axil_data_t'(dio_in_i);
      `CHIP_REG_STATUS:     rd_data = chip_pkg::axil_data_t'(init_done_i);
      default:              rd_ok   = 1'b0;
    endcase
  end

  //////////////////////////////
  // pad registers
  //////////////////////////////

  // held at zero until the power sequence is done
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mio_out_q <= '0;
      mio_oe_q  <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
    end else if (!init_done_i) begin
      mio_out_q <= '0;
      mio_oe_q  <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
    end else if (aw_fire && wr_ok) begin
      case (axil_req_i.awaddr)
        `CHIP_REG_MIO_OUT_LO: mio_out_q[31:0] <= axil_req_i.wdata;
        `CHIP_REG_MIO_OUT_HI: mio_out_q[`CHIP_MIO_PADS-1:32] <= axil_req_i.wdata[7:0];
        `CHIP_REG_MIO_OE_LO:  mio_oe_q[31:0] <= axil_req_i.wdata;
        `CHIP_REG_MIO_OE_HI:  mio_oe_q[`CHIP_MIO_PADS-1:32] <= axil_req_i.wdata[7:0];
        `CHIP_REG_DIO_OUT:    dio_out_q <= axil_req_i.wdata[`CHIP_DIO_PADS-1:0];
        `CHIP_REG_DIO_OE:     dio_oe_q <= axil_req_i.wdata[`CHIP_DIO_PADS-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // response channels
  //////////////////////////////

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_state_q <= WR_IDLE;
    end else if (aw_fire) begin
      wr_state_q <= WR_RESP;
    end else if ((wr_state_q == WR_RESP) && axil_req_i.bready) begin
      wr_state_q <= WR_IDLE;
    end
  end

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= RD_IDLE;
    end else if (ar_fire) begin
      rd_state_q <= RD_RESP;
    end else if ((rd_state_q == RD_RESP) && axil_req_i.rready) begin
      rd_state_q <= RD_IDLE;
    end
  end

  // payload captured at acceptance
  always_ff @(posedge clk_aon) begin
    if (aw_fire) begin
      bresp_q <= wr_ok ? chip_pkg::AXIL_OKAY : chip_pkg::AXIL_SLVERR;
    end
    if (ar_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_ok ? chip_pkg::AXIL_OKAY : chip_pkg::AXIL_SLVERR;
    end
  end

  always_comb begin
    axil_rsp_o.awready = aw_fire;
    axil_rsp_o.wready  = aw_fire;
    axil_rsp_o.bvalid  = (wr_state_q == WR_RESP);
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = ar_fire;
    axil_rsp_o.rvalid  = (rd_state_q == RD_RESP);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign mio_out_o = mio_out_q;
  assign mio_oe_o  = mio_oe_q;
  assign dio_out_o = dio_out_q;
  assign dio_oe_o  = dio_oe_q;

  b_stable_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    axil_rsp_o.bvalid && !axil_req_i.bready
    |=> axil_rsp_o.bvalid && $stable(axil_rsp_o.bresp));

  r_stable_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    axil_rsp_o.rvalid && !axil_req_i.rready
    |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata) && $stable(axil_rsp_o.rresp));

endmodule

`default_nettype wire

// ==== logic/pad_map.sv ====
//////////////////////////////
// chip pins to MIO/DIO pads
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chip_cfg.svh"

module pad_map (
  input  wire chip_pkg::gpio_vec_t gpio_i,
  input  wire                      uart_rx_i,
  input  wire                      usb_sense_i,
  input  wire                      spi_sck_i,
  input  wire                      spi_csb_i,
  input  wire                      spi_sdi_i,
  input  wire                      usb_dp_i,
  input  wire                      usb_dn_i,
  output chip_pkg::gpio_vec_t      gpio_o,
  output chip_pkg::gpio_vec_t      gpio_en_o,
  output logic                     uart_tx_o,
  output logic                     uart_tx_en_o,
  output logic                     spi_sdo_o,
  output logic                     spi_sdo_en_o,
  output logic                     usb_dp_o,
  output logic                     usb_dp_en_o,
  output logic                     usb_dn_o,
  output logic                     usb_dn_en_o,
  input  wire chip_pkg::mio_vec_t  mio_out_i,
  input  wire chip_pkg::mio_vec_t  mio_oe_i,
  input  wire chip_pkg::dio_vec_t  dio_out_i,
  input  wire chip_pkg::dio_vec_t  dio_oe_i,
  output chip_pkg::mio_vec_t       mio_in_o,
  output chip_pkg::dio_vec_t       dio_in_o
);

  localparam int unsigned GpioW = $bits(chip_pkg::gpio_vec_t);

  // pins into the pad vectors
  always_comb begin
    mio_in_o                       = '0;
    mio_in_o[GpioW-1:0]            = gpio_i;
    mio_in_o[`CHIP_MIO_UART_RX]    = uart_rx_i;
    mio_in_o[`CHIP_MIO_USB_SENSE0] = usb_sense_i;
    mio_in_o[`CHIP_MIO_USB_SENSE1] = usb_sense_i;
  end

  always_comb begin
    dio_in_o                    = '0;
    dio_in_o[`CHIP_DIO_SPI_SCK] = spi_sck_i;
    dio_in_o[`CHIP_DIO_SPI_CSB] = spi_csb_i;
    dio_in_o[`CHIP_DIO_SPI_SD0] = spi_sdi_i;
    dio_in_o[`CHIP_DIO_USB_DP]  = usb_dp_i;
    dio_in_o[`CHIP_DIO_USB_DN]  = usb_dn_i;
  end

  // gpio pin 26 belongs to the uart tx
  always_comb begin
    gpio_o                       = mio_out_i[GpioW-1:0];
    gpio_en_o                    = mio_oe_i[GpioW-1:0];
    gpio_o[`CHIP_MIO_UART_TX]    = 1'b0;
    gpio_en_o[`CHIP_MIO_UART_TX] = 1'b0;
  end

  assign uart_tx_o    = mio_out_i[`CHIP_MIO_UART_TX];
  assign uart_tx_en_o = mio_oe_i[`CHIP_MIO_UART_TX];

  // dedicated outputs
  assign spi_sdo_o    = dio_out_i[`CHIP_DIO_SPI_SD1];
  assign spi_sdo_en_o = dio_oe_i[`CHIP_DIO_SPI_SD1];
  assign usb_dp_o     = dio_out_i[`CHIP_DIO_USB_DP];
  assign usb_dp_en_o  = dio_oe_i[`CHIP_DIO_USB_DP];
  assign usb_dn_o     = dio_out_i[`CHIP_DIO_USB_DN];
  assign usb_dn_en_o  = dio_oe_i[`CHIP_DIO_USB_DN];

endmodule

`default_nettype wire

// ==== logic/por_sequencer.sv ====
//////////////////////////////
// fake supply sequence
// power-ok filter, init-done
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chip_cfg.svh"

module por_sequencer (
  input  wire  clk_aon,
  input  wire  arst_n_i,
  output logic init_done_o
);

  localparam int unsigned PokFilter = `CHIP_POK_FILTER;
  localparam int unsigned FiltW     = $clog2(PokFilter + 1);
  localparam logic [3:0]  CntSat    = 4'hf;

  logic [3:0]       cnt_q;
  logic [FiltW-1:0] hi_cnt_q;
  logic             supply;
  logic             pok;

  // walk the sequence once, then park
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != CntSat) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // low, high, low, then high for good
  assign supply = (cnt_q < 4'd4)  ? 1'b0 :
                  (cnt_q < 4'd8)  ? 1'b1 :
                  (cnt_q < 4'd12) ? 1'b0 : 1'b1;

  // count consecutive high cycles
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hi_cnt_q <= '0;
    end else if (!supply) begin
      hi_cnt_q <= '0;
    end else if (hi_cnt_q < FiltW'(PokFilter)) begin
      hi_cnt_q <= hi_cnt_q + 1'b1;
    end
  end

  // drops with the supply, no filter on the way down
  assign pok = supply && (hi_cnt_q == FiltW'(PokFilter));

  // sticky once the sequence has settled
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_done_o <= 1'b0;
    end else if ((cnt_q == CntSat) && pok) begin
      init_done_o <= 1'b1;
    end
  end

  init_done_sticky_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    init_done_o |=> init_done_o);

endmodule

`default_nettype wire

// ==== testbench/tb_chip_sim.sv ====
//////////////////////////////
// testbench for the chip wrapper
// AXI4-Lite tasks, pin checks
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "chip_cfg.svh"

module tb_chip_sim;

  localparam int unsigned BusTimeout  = 20;
  localparam int unsigned InitTimeout = 40;

  logic                clk_aon;
  logic                arst_n_i;
  chip_pkg::axil_req_t req;
  chip_pkg::axil_rsp_t rsp;
  logic                init_done_o;
  chip_pkg::gpio_vec_t gpio_i;
  logic                uart_rx_i;
  logic                usb_sense_i;
  logic                spi_sck_i;
  logic                spi_csb_i;
  logic                spi_sdi_i;
  logic                usb_dp_i;
  logic                usb_dn_i;
  chip_pkg::gpio_vec_t gpio_o;
  chip_pkg::gpio_vec_t gpio_en_o;
  logic                uart_tx_o;
  logic                uart_tx_en_o;
  logic                spi_sdo_o;
  logic                spi_sdo_en_o;
  logic                usb_dp_o;
  logic                usb_dp_en_o;
  logic                usb_dn_o;
  logic                usb_dn_en_o;
  logic [71:0]         pin_drive;
  logic [31:0]         rng;

  chip_sim_top dut0 (
    .clk_aon      (clk_aon),
    .arst_n_i     (arst_n_i),
    .axil_req_i   (req),
    .axil_rsp_o   (rsp),
    .init_done_o  (init_done_o),
    .gpio_i       (gpio_i),
    .uart_rx_i    (uart_rx_i),
    .usb_sense_i  (usb_sense_i),
    .spi_sck_i    (spi_sck_i),
    .spi_csb_i    (spi_csb_i),
    .spi_sdi_i    (spi_sdi_i),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o),
    .usb_dp_o     (usb_dp_o),
    .usb_dp_en_o  (usb_dp_en_o),
    .usb_dn_o     (usb_dn_o),
    .usb_dn_en_o  (usb_dn_en_o)
  );

  // every pin output and enable in one vector
  assign pin_drive = {gpio_o, gpio_en_o, uart_tx_o, uart_tx_en_o, spi_sdo_o, spi_sdo_en_o,
                      usb_dp_o, usb_dp_en_o, usb_dn_o, usb_dn_en_o};

  initial begin : clock_gen
    clk_aon = 1'b0;
    forever #20 clk_aon = ~clk_aon;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [79:0] got, input logic [79:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // xorshift32
  function automatic logic [31:0] random_word();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic bus_write(input chip_pkg::axil_addr_t addr, input chip_pkg::axil_data_t data,
                           input int unsigned stall, output chip_pkg::axil_resp_t resp);
    int unsigned n;
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.bready  <= (stall == 0);
    n = 0;
    do begin
      @(posedge clk_aon);
      n++;
      if (n > BusTimeout) stop_on_error("write address and data were not accepted in time");
    end while (!(rsp.awready && rsp.wready));
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_aon);
      n++;
      if (n > BusTimeout) stop_on_error("write response did not arrive in time");
    end while (!rsp.bvalid);
    resp = rsp.bresp;
    // response must hold while bready is low
    if (stall > 0) begin
      repeat (stall) begin
        @(posedge clk_aon);
        expect_eq("bvalid", rsp.bvalid, 1'b1);
        expect_eq("bresp", rsp.bresp, resp);
      end
      req.bready <= 1'b1;
      @(posedge clk_aon);
    end
  endtask

  task automatic bus_read(input chip_pkg::axil_addr_t addr, input int unsigned stall,
                          output chip_pkg::axil_data_t data, output chip_pkg::axil_resp_t resp);
    int unsigned n;
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    req.rready  <= (stall == 0);
    n = 0;
    do begin
      @(posedge clk_aon);
      n++;
      if (n > BusTimeout) stop_on_error("read address was not accepted in time");
    end while (!rsp.arready);
    req.arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_aon);
      n++;
      if (n > BusTimeout) stop_on_error("read response did not arrive in time");
    end while (!rsp.rvalid);
    data = rsp.rdata;
    resp = rsp.rresp;
    // payload must hold while rready is low
    if (stall > 0) begin
      repeat (stall) begin
        @(posedge clk_aon);
        expect_eq("rvalid", rsp.rvalid, 1'b1);
        expect_eq("rdata", rsp.rdata, data);
        expect_eq("rresp", rsp.rresp, resp);
      end
      req.rready <= 1'b1;
      @(posedge clk_aon);
    end
  endtask

  task automatic write_ok(input chip_pkg::axil_addr_t addr, input chip_pkg::axil_data_t data);
    chip_pkg::axil_resp_t resp;
    bus_write(addr, data, 0, resp);
    expect_eq("bresp", resp, chip_pkg::AXIL_OKAY);
  endtask

  task automatic read_expect(input chip_pkg::axil_addr_t addr, input chip_pkg::axil_data_t exp);
    chip_pkg::axil_data_t data;
    chip_pkg::axil_resp_t resp;
    bus_read(addr, 0, data, resp);
    expect_eq("rresp", resp, chip_pkg::AXIL_OKAY);
    expect_eq($sformatf("rdata at 0x%02h", addr), data, exp);
  endtask

  //////////////////////////////
  // pin assertions
  //////////////////////////////

  uart_pin_low_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    !gpio_o[`CHIP_MIO_UART_TX] && !gpio_en_o[`CHIP_MIO_UART_TX])
    else stop_on_error($sformatf("Error: gpio_o[26] = 0x%0h, gpio_en_o[26] = 0x%0h, expected 0x0",
                                 gpio_o[`CHIP_MIO_UART_TX], gpio_en_o[`CHIP_MIO_UART_TX]));

  pads_off_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    !init_done_o |-> (pin_drive == '0))
    else stop_on_error($sformatf("Error: pin_drive = 0x%0h before init done, expected 0x0",
                                 pin_drive));

  initial begin : stimulus
    chip_pkg::axil_data_t data;
    chip_pkg::axil_data_t bits;
    chip_pkg::axil_resp_t resp;
    chip_pkg::axil_data_t out_lo;
    chip_pkg::axil_data_t out_hi;
    chip_pkg::axil_data_t oe_lo;
    chip_pkg::axil_data_t oe_hi;
    chip_pkg::gpio_vec_t  exp_gpio;
    chip_pkg::mio_vec_t   exp_mio;
    chip_pkg::dio_vec_t   exp_dio;
    chip_pkg::dio_vec_t   dio_out;
    chip_pkg::dio_vec_t   dio_oe;
    int unsigned          n;

    rng         = 32'd88576;
    req         = '0;
    req.wstrb   = 4'hf;
    req.bready  = 1'b1;
    req.rready  = 1'b1;
    gpio_i      = '0;
    uart_rx_i   = 1'b0;
    usb_sense_i = 1'b0;
    spi_sck_i   = 1'b0;
    spi_csb_i   = 1'b0;
    spi_sdi_i   = 1'b0;
    usb_dp_i    = 1'b0;
    usb_dn_i    = 1'b0;
    arst_n_i    = 1'b0;
    repeat (16) @(posedge clk_aon);
    arst_n_i <= 1'b1;

    // power sequence still running
    read_expect(`CHIP_REG_STATUS, 32'h0);
    bus_write(`CHIP_REG_MIO_OUT_LO, 32'hffff_ffff, 0, resp);
    expect_eq("bresp", resp, chip_pkg::AXIL_SLVERR);
    expect_eq("pin_drive", pin_drive, '0);
    n = 0;
    while (!init_done_o) begin
      @(posedge clk_aon);
      n++;
      if (n > InitTimeout) stop_on_error("init_done_o did not rise within 40 cycles");
    end
    read_expect(`CHIP_REG_STATUS, 32'h1);

    // MIO outputs onto the gpio and uart pins
    for (int i = 0; i < 4; i++) begin
      out_lo = random_word();
      out_hi = random_word();
      oe_lo  = random_word();
      oe_hi  = random_word();
      write_ok(`CHIP_REG_MIO_OUT_LO, out_lo);
      write_ok(`CHIP_REG_MIO_OUT_HI, out_hi);
      write_ok(`CHIP_REG_MIO_OE_LO, oe_lo);
      write_ok(`CHIP_REG_MIO_OE_HI, oe_hi);
      exp_gpio = out_lo;
      exp_gpio[`CHIP_MIO_UART_TX] = 1'b0;
      expect_eq("gpio_o", gpio_o, exp_gpio);
      exp_gpio = oe_lo;
      exp_gpio[`CHIP_MIO_UART_TX] = 1'b0;
      expect_eq("gpio_en_o", gpio_en_o, exp_gpio);
      expect_eq("uart_tx_o", uart_tx_o, out_lo[`CHIP_MIO_UART_TX]);
      expect_eq("uart_tx_en_o", uart_tx_en_o, oe_lo[`CHIP_MIO_UART_TX]);
      read_expect(`CHIP_REG_MIO_OUT_LO, out_lo);
      read_expect(`CHIP_REG_MIO_OUT_HI, out_hi & 32'h0000_00ff);
      read_expect(`CHIP_REG_MIO_OE_LO, oe_lo);
      read_expect(`CHIP_REG_MIO_OE_HI, oe_hi & 32'h0000_00ff);
    end

    // pin inputs back through the pad vectors
    for (int i = 0; i < 4; i++) begin
      data = random_word();
      bits = random_word();
      gpio_i      <= data;
      uart_rx_i   <= bits[0];
      usb_sense_i <= bits[1];
      spi_sck_i   <= bits[2];
      spi_csb_i   <= bits[3];
      spi_sdi_i   <= bits[4];
      usb_dp_i    <= bits[5];
      usb_dn_i    <= bits[6];
      exp_mio = '0;
      exp_mio[31:0] = data;
      exp_mio[`CHIP_MIO_UART_RX]    = bits[0];
      exp_mio[`CHIP_MIO_USB_SENSE0] = bits[1];
      exp_mio[`CHIP_MIO_USB_SENSE1] = bits[1];
      exp_dio = '0;
      exp_dio[`CHIP_DIO_SPI_SCK] = bits[2];
      exp_dio[`CHIP_DIO_SPI_CSB] = bits[3];
      exp_dio[`CHIP_DIO_SPI_SD0] = bits[4];
      exp_dio[`CHIP_DIO_USB_DP]  = bits[5];
      exp_dio[`CHIP_DIO_USB_DN]  = bits[6];
      read_expect(`CHIP_REG_MIO_IN_LO, exp_mio[31:0]);
      read_expect(`CHIP_REG_MIO_IN_HI, {24'h0, exp_mio[39:32]});
      read_expect(`CHIP_REG_DIO_IN, {24'h0, exp_dio});
    end

    // dedicated outputs
    for (int i = 0; i < 3; i++) begin
      data    = random_word();
      dio_out = data[7:0];
      dio_oe  = data[15:8];
      write_ok(`CHIP_REG_DIO_OUT, {24'h0, dio_out});
      write_ok(`CHIP_REG_DIO_OE, {24'h0, dio_oe});
      expect_eq("spi_sdo_o", spi_sdo_o, dio_out[`CHIP_DIO_SPI_SD1]);
      expect_eq("spi_sdo_en_o", spi_sdo_en_o, dio_oe[`CHIP_DIO_SPI_SD1]);
      expect_eq("usb_dp_o", usb_dp_o, dio_out[`CHIP_DIO_USB_DP]);
      expect_eq("usb_dp_en_o", usb_dp_en_o, dio_oe[`CHIP_DIO_USB_DP]);
      expect_eq("usb_dn_o", usb_dn_o, dio_out[`CHIP_DIO_USB_DN]);
      expect_eq("usb_dn_en_o", usb_dn_en_o, dio_oe[`CHIP_DIO_USB_DN]);
      read_expect(`CHIP_REG_DIO_OUT, {24'h0, dio_out});
      read_expect(`CHIP_REG_DIO_OE, {24'h0, dio_oe});
    end

    // error responses and back-pressure
    bus_write(`CHIP_REG_DIO_IN, random_word(), 4, resp);
    expect_eq("bresp", resp, chip_pkg::AXIL_SLVERR);
    bus_read(8'h30, 0, data, resp);
    expect_eq("rresp", resp, chip_pkg::AXIL_SLVERR);
    expect_eq("rdata", data, 32'h0);
    bus_read(`CHIP_REG_MIO_OUT_LO, 6, data, resp);
    expect_eq("rresp", resp, chip_pkg::AXIL_OKAY);
    expect_eq("rdata", data, out_lo);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/chip_pkg.sv
logic/por_sequencer.sv
logic/pad_map.sv
logic/pad_ctrl_regs.sv
logic/chip_sim_top.sv
testbench/tb_chip_sim.sv
